/* rtl/btb_entry.sv */
// ====================
// single btb entry with search and probe tag compare
// ====================

`timescale 1ns/1ps

module btb_entry (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  btb_update_if.entry            btb_upd,
  btb_lookup_if.entry            btb_lkp,
  input  frontend_pkg::btb_idx_t i_idx
);
  import frontend_pkg::*;

  logic   r_valid;
  vaddr_t r_tag;
  vaddr_t r_target;
  logic   w_we;

  // own strobe out of the shared write vector
  assign w_we = btb_upd.we[i_idx];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else if (w_we) begin
      r_valid <= btb_upd.set_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_we) begin
      r_tag    <= btb_upd.tag;
      r_target <= btb_upd.target;
    end
  end

  // s0 fetch search
  assign btb_lkp.hit[i_idx] = r_valid & btb_lkp.search_valid &
                              (r_tag == btb_lkp.search_vaddr);
  assign btb_lkp.target[i_idx] = r_target;

  // branch update probe
  assign btb_lkp.probe_hit[i_idx] = r_valid & (r_tag == btb_lkp.probe_vaddr);

endmodule

/* rtl/btb_hit_select.sv */
// ====================
// btb hit merge into one registered prediction
// ====================

`timescale 1ns/1ps

`include "frontend_defines.svh"

module btb_hit_select (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  btb_lookup_if.select         btb_sel,
  output logic                 o_pred_hit,
  output frontend_pkg::vaddr_t o_pred_target
);
  import frontend_pkg::*;

  logic   w_hit;
  vaddr_t w_target;
  logic   r_hit;
  vaddr_t r_target;

  assign w_hit = |btb_sel.hit;

  // tags are unique so an or of the hit slots is enough
  always_comb begin
    w_target = '0;
    for (int i = 0; i < `FE_BTB_ENTRIES; i++) begin
      if (btb_sel.hit[i]) begin
        w_target = w_target | btb_sel.target[i];
      end
    end
  end

  // result follows the block into s1, held while s1 stalls
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_hit <= 1'b0;
    end else if (btb_sel.search_valid) begin
      r_hit <= w_hit;
    end
  end

  always_ff @(posedge i_clk) begin
    if (btb_sel.search_valid) begin
      r_target <= w_target;
    end
  end

  assign o_pred_hit    = r_hit;
  assign o_pred_target = r_target;

  // update controller must never install a duplicate tag
  a_single_hit : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    btb_sel.search_valid |-> $onehot0(btb_sel.hit))
    else $error("btb_hit_select multiple entries hit %b", btb_sel.hit);

endmodule

/* rtl/btb_update_ctrl.sv */
// ====================
// btb write control with round-robin victim choice
// ====================

`timescale 1ns/1ps

`include "frontend_defines.svh"

module btb_update_ctrl (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_br_valid,
  input  logic                 i_br_taken,
  input  frontend_pkg::vaddr_t i_br_pc,
  input  frontend_pkg::vaddr_t i_br_target,
  btb_update_if.ctrl           btb_upd,
  btb_lookup_if.probe          btb_probe
);
  import frontend_pkg::*;

  btb_idx_t r_victim;
  btb_vec_t w_victim_vec;
  logic     w_match;
  logic     w_install;

  // probe the entries for the branch block
  assign btb_probe.probe_vaddr = block_align(i_br_pc);
  assign w_match               = |btb_probe.probe_hit;

  // new block only when no entry holds it yet
  assign w_install    = i_br_valid & i_br_taken & ~w_match;
  assign w_victim_vec = btb_vec_t'(1) << r_victim;

  always_comb begin
    btb_upd.we = '0;
    if (i_br_valid) begin
      // matching entry is rewritten or cleared in place
      btb_upd.we = w_install ? w_victim_vec : btb_probe.probe_hit;
    end
  end

  assign btb_upd.set_valid = i_br_taken;
  assign btb_upd.tag       = block_align(i_br_pc);
  assign btb_upd.target    = i_br_target;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_victim <= '0;
    end else if (w_install) begin
      r_victim <= (r_victim == btb_idx_t'(`FE_BTB_ENTRIES - 1)) ? '0 : r_victim + 1'b1;
    end
  end

endmodule

/* rtl/fetch_pc_gen.sv */
// ====================
// fetch address generator with s0 address and s1 output stage
// ====================

`timescale 1ns/1ps

`include "frontend_defines.svh"

module fetch_pc_gen (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_redirect,
  input  frontend_pkg::vaddr_t i_redirect_vaddr,
  input  logic                 i_pred_hit,
  input  frontend_pkg::vaddr_t i_pred_target,
  input  logic                 i_ibuf_ready,
  btb_lookup_if.search         btb_search,
  output logic                 o_fetch_valid,
  output frontend_pkg::vaddr_t o_fetch_vaddr,
  output logic                 o_fetch_pred_taken,
  output frontend_pkg::vaddr_t o_fetch_pred_target
);
  import frontend_pkg::*;

  vaddr_t r_s0_vaddr;
  vaddr_t w_s0_vaddr_next;
  logic   r_s1_valid;
  vaddr_t r_s1_vaddr;
  logic   w_s1_adv;
  logic   w_s1_accept;
  logic   w_pred_redirect;
  logic   w_s1_load;

  // ====================
  // stage control
  // ====================

  // s1 can take a new block when empty or draining
  assign w_s1_adv    = ~r_s1_valid | i_ibuf_ready;
  assign w_s1_accept = r_s1_valid & i_ibuf_ready;

  // taken prediction on a delivered block
  assign w_pred_redirect = w_s1_accept & i_pred_hit;

  // s0 block moves on unless killed or replaced
  assign w_s1_load = w_s1_adv & ~i_redirect & ~w_pred_redirect;

  // ====================
  // s0 next address
  // ====================

  always_comb begin
    if (i_redirect) begin
      w_s0_vaddr_next = block_align(i_redirect_vaddr);
    end else if (!w_s1_adv) begin
      // buffer full, replay same block later
      w_s0_vaddr_next = r_s0_vaddr;
    end else if (w_pred_redirect) begin
      // sequential block in s0 is dropped
      w_s0_vaddr_next = block_align(i_pred_target);
    end else begin
      w_s0_vaddr_next = r_s0_vaddr + vaddr_t'(`FE_BLOCK_BYTES);
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s0_vaddr <= vaddr_t'(`FE_RESET_VADDR);
    end else begin
      r_s0_vaddr <= w_s0_vaddr_next;
    end
  end

  // ====================
  // s1 stage
  // ====================

  // kill on any redirect, hold while stalled
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
    end else if (i_redirect || w_s1_adv) begin
      r_s1_valid <= w_s1_load;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_s1_load) begin
      r_s1_vaddr <= r_s0_vaddr;
    end
  end

  // btb looks up the s0 block, result lands with it in s1
  assign btb_search.search_valid = w_s1_load;
  assign btb_search.search_vaddr = r_s0_vaddr;

  assign o_fetch_valid       = r_s1_valid;
  assign o_fetch_vaddr       = r_s1_vaddr;
  assign o_fetch_pred_taken  = r_s1_valid & i_pred_hit;
  assign o_fetch_pred_target = i_pred_target;

  // every path into s0 aligns, including btb and csr targets
  a_fetch_aligned : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_fetch_valid |-> block_align(o_fetch_vaddr) == o_fetch_vaddr)
    else $error("fetch_pc_gen unaligned block %h", o_fetch_vaddr);

endmodule

/* rtl/fetch_redirect.sv */
// ====================
// flush target selection from commit, csr and branch inputs
// ====================

`timescale 1ns/1ps

`include "frontend_defines.svh"

module fetch_redirect (
  input  logic                      i_cmt_flush,
  input  frontend_pkg::flush_kind_t i_cmt_kind,
  input  frontend_pkg::vaddr_t      i_cmt_epc,
  input  frontend_pkg::cause_t      i_cmt_cause,
  input  frontend_pkg::vaddr_t      i_csr_mtvec,
  input  frontend_pkg::vaddr_t      i_csr_stvec,
  input  frontend_pkg::vaddr_t      i_csr_mepc,
  input  frontend_pkg::vaddr_t      i_csr_sepc,
  input  frontend_pkg::medeleg_t    i_csr_medeleg,
  input  logic                      i_br_valid,
  input  logic                      i_br_mispredict,
  input  logic                      i_br_taken,
  input  frontend_pkg::vaddr_t      i_br_pc,
  input  frontend_pkg::vaddr_t      i_br_target,
  output logic                      o_redirect,
  output frontend_pkg::vaddr_t      o_redirect_vaddr
);
  import frontend_pkg::*;

  logic   w_br_flush;
  vaddr_t w_cmt_vaddr;
  vaddr_t w_br_vaddr;
  vaddr_t w_int_base;

  // ====================
  // commit flush target
  // ====================

  // vectored mode bit dropped from mtvec
  assign w_int_base = i_csr_mtvec & ~vaddr_t'(1);

  always_comb begin
    case (i_cmt_kind)
      // resume after the flushing instruction
      SILENT:  w_cmt_vaddr = i_cmt_epc + vaddr_t'(4);
      REFETCH: w_cmt_vaddr = i_cmt_epc;
      MRET:    w_cmt_vaddr = i_csr_mepc;
      SRET:    w_cmt_vaddr = i_csr_sepc;
      EXCEPT: begin
        // delegated causes trap to supervisor
        if (i_csr_medeleg[i_cmt_cause]) begin
          w_cmt_vaddr = i_csr_stvec;
        end else begin
          w_cmt_vaddr = i_csr_mtvec;
        end
      end
      // one vector slot per cause
      INTERRUPT: w_cmt_vaddr = w_int_base + vaddr_t'({i_cmt_cause, 2'b00});
      default:   w_cmt_vaddr = i_cmt_epc;
    endcase
  end

  // ====================
  // branch flush target
  // ====================

  assign w_br_flush = i_br_valid & i_br_mispredict;

  // not taken resumes at the block after the branch
  assign w_br_vaddr = i_br_taken ? i_br_target
                                 : block_align(i_br_pc) + vaddr_t'(`FE_BLOCK_BYTES);

  // commit flush is older, so it wins
  assign o_redirect       = i_cmt_flush | w_br_flush;
  assign o_redirect_vaddr = i_cmt_flush ? w_cmt_vaddr : w_br_vaddr;

  // kind must decode whenever the committer flushes
  always_comb begin
    if (i_cmt_flush) begin
      assert final (i_cmt_kind inside {SILENT, REFETCH, MRET, SRET, EXCEPT, INTERRUPT})
        else $error("fetch_redirect illegal flush kind %0d", i_cmt_kind);
    end
  end

endmodule

/* rtl/frontend_defines.svh */
// ====================
// fetch front end widths and sizes
// ====================

`ifndef FRONTEND_DEFINES_SVH
`define FRONTEND_DEFINES_SVH

// virtual address width
`define FE_XLEN 32

// bytes per fetch block, power of two
`define FE_BLOCK_BYTES 8

// branch target buffer depth
`define FE_BTB_ENTRIES 4

// first fetch address out of reset, block aligned
`define FE_RESET_VADDR 32'h0000_1000

// exception and interrupt code width
`define FE_CAUSE_W 4

`endif

/* rtl/frontend_ifs.sv */
// ====================
// btb write port and btb search port bundles
// ====================

`timescale 1ns/1ps

`include "frontend_defines.svh"

// write strobes from the update controller to every entry
interface btb_update_if;
  import frontend_pkg::*;

  // one write strobe per entry
  btb_vec_t we;
  // high installs, low invalidates
  logic     set_valid;
  // block address of the branch
  vaddr_t   tag;
  vaddr_t   target;

  modport ctrl  (output we, set_valid, tag, target);
  modport entry (input  we, set_valid, tag, target);
endinterface

// s0 search plus the branch probe search into the same entries
interface btb_lookup_if;
  import frontend_pkg::*;

  logic     search_valid;
  vaddr_t   search_vaddr;
  // per entry results, each entry fills its own slot
  btb_vec_t hit;
  vaddr_t   target [`FE_BTB_ENTRIES];
  // second tag compare for the update path
  vaddr_t   probe_vaddr;
  btb_vec_t probe_hit;

  modport search (output search_valid, search_vaddr);
  modport entry  (input  search_valid, search_vaddr, probe_vaddr,
                  output hit, target, probe_hit);
  modport select (input  search_valid, hit, target);
  modport probe  (output probe_vaddr, input probe_hit);
endinterface

/* rtl/frontend_pkg.sv */
// ====================
// fetch front end types and the block alignment helper
// ====================

`include "frontend_defines.svh"

package frontend_pkg;

  // ====================
  // address and csr types
  // ====================

  typedef logic [`FE_XLEN-1:0] vaddr_t;

  // exception or interrupt code
  typedef logic [`FE_CAUSE_W-1:0] cause_t;

  // one delegation bit per exception cause
  typedef logic [15:0] medeleg_t;

  // ====================
  // btb types
  // ====================

  typedef logic [$clog2(`FE_BTB_ENTRIES)-1:0] btb_idx_t;

  // one bit per btb entry
  typedef logic [`FE_BTB_ENTRIES-1:0] btb_vec_t;

  // commit flush reasons
  typedef enum logic [2:0] {
    SILENT    = 3'd0,
    REFETCH   = 3'd1,
    MRET      = 3'd2,
    SRET      = 3'd3,
    EXCEPT    = 3'd4,
    INTERRUPT = 3'd5
  } flush_kind_t;

  // clear the byte offset inside a fetch block
  function automatic vaddr_t block_align(vaddr_t vaddr);
    return vaddr & ~vaddr_t'(`FE_BLOCK_BYTES - 1);
  endfunction

endpackage

/* rtl/frontend_top.sv */
// ====================
// fetch front end top with redirect, address generator and btb
// ====================

`timescale 1ns/1ps

`include "frontend_defines.svh"

module frontend_top (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  // commit flush
  input  logic                      i_cmt_flush,
  input  frontend_pkg::flush_kind_t i_cmt_kind,
  input  frontend_pkg::vaddr_t      i_cmt_epc,
  input  frontend_pkg::cause_t      i_cmt_cause,
  // csr state
  input  frontend_pkg::vaddr_t      i_csr_mtvec,
  input  frontend_pkg::vaddr_t      i_csr_stvec,
  input  frontend_pkg::vaddr_t      i_csr_mepc,
  input  frontend_pkg::vaddr_t      i_csr_sepc,
  input  frontend_pkg::medeleg_t    i_csr_medeleg,
  // branch resolution
  input  logic                      i_br_valid,
  input  logic                      i_br_mispredict,
  input  logic                      i_br_taken,
  input  frontend_pkg::vaddr_t      i_br_pc,
  input  frontend_pkg::vaddr_t      i_br_target,
  // instruction buffer side
  input  logic                      i_ibuf_ready,
  output logic                      o_fetch_valid,
  output frontend_pkg::vaddr_t      o_fetch_vaddr,
  output logic                      o_fetch_pred_taken,
  output frontend_pkg::vaddr_t      o_fetch_pred_target
);
  import frontend_pkg::*;

  logic   w_redirect;
  vaddr_t w_redirect_vaddr;
  logic   w_pred_hit;
  vaddr_t w_pred_target;

  btb_update_if w_btb_upd ();
  btb_lookup_if w_btb_lkp ();

  // ====================
  // redirect and fetch address
  // ====================

  fetch_redirect u_fetch_redirect (
    .i_cmt_flush      (i_cmt_flush),
    .i_cmt_kind       (i_cmt_kind),
    .i_cmt_epc        (i_cmt_epc),
    .i_cmt_cause      (i_cmt_cause),
    .i_csr_mtvec      (i_csr_mtvec),
    .i_csr_stvec      (i_csr_stvec),
    .i_csr_mepc       (i_csr_mepc),
    .i_csr_sepc       (i_csr_sepc),
    .i_csr_medeleg    (i_csr_medeleg),
    .i_br_valid       (i_br_valid),
    .i_br_mispredict  (i_br_mispredict),
    .i_br_taken       (i_br_taken),
    .i_br_pc          (i_br_pc),
    .i_br_target      (i_br_target),
    .o_redirect       (w_redirect),
    .o_redirect_vaddr (w_redirect_vaddr)
  );

  fetch_pc_gen u_fetch_pc_gen (
    .i_clk               (i_clk),
    .i_reset_n           (i_reset_n),
    .i_redirect          (w_redirect),
    .i_redirect_vaddr    (w_redirect_vaddr),
    .i_pred_hit          (w_pred_hit),
    .i_pred_target       (w_pred_target),
    .i_ibuf_ready        (i_ibuf_ready),
    .btb_search          (w_btb_lkp),
    .o_fetch_valid       (o_fetch_valid),
    .o_fetch_vaddr       (o_fetch_vaddr),
    .o_fetch_pred_taken  (o_fetch_pred_taken),
    .o_fetch_pred_target (o_fetch_pred_target)
  );

  // ====================
  // branch target buffer
  // ====================

  btb_update_ctrl u_btb_update_ctrl (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_br_valid  (i_br_valid),
    .i_br_taken  (i_br_taken),
    .i_br_pc     (i_br_pc),
    .i_br_target (i_br_target),
    .btb_upd     (w_btb_upd),
    .btb_probe   (w_btb_lkp)
  );

  // identical entries, each told its own slot
  for (genvar g = 0; g < `FE_BTB_ENTRIES; g++) begin : g_btb_entry
    btb_entry u_btb_entry (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .btb_upd   (w_btb_upd),
      .btb_lkp   (w_btb_lkp),
      .i_idx     (btb_idx_t'(g))
    );
  end

  btb_hit_select u_btb_hit_select (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .btb_sel       (w_btb_lkp),
    .o_pred_hit    (w_pred_hit),
    .o_pred_target (w_pred_target)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the fetch front end testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_frontend -Mdir obj_dir

./obj_dir/Vtb_frontend > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "simulation reported errors, see sim.log"
  exit 1
fi

/* src.f */
+incdir+rtl
+incdir+testbench
rtl/frontend_pkg.sv
rtl/frontend_ifs.sv
rtl/fetch_redirect.sv
rtl/fetch_pc_gen.sv
rtl/btb_update_ctrl.sv
rtl/btb_entry.sv
rtl/btb_hit_select.sv
rtl/frontend_top.sv
testbench/tb_frontend.sv

/* testbench/tb_frontend_tasks.svh */
// ====================
// compare tasks, stimulus helpers and directed tests for the front end
// ====================

`ifndef TB_FRONTEND_TASKS_SVH
`define TB_FRONTEND_TASKS_SVH

// ====================
// compare tasks
// ====================

task automatic check_vaddr(input string name, input vaddr_t expected, input vaddr_t actual);
  check_count++;
  if (expected !== actual) begin
    $display("FAILED %s expected %h actual %h", name, expected, actual);
    error_count++;
  end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
  check_count++;
  if (expected !== actual) begin
    $display("FAILED %s expected %b actual %b", name, expected, actual);
    error_count++;
  end
endtask

task automatic report_test(input string name, input int start_errors);
  $display("test %-16s done, %0d errors", name, error_count - start_errors);
endtask

// ====================
// reference model
// ====================

// round down to the start of the fetch block
function automatic vaddr_t align_down(vaddr_t addr);
  return addr - (addr % `FE_BLOCK_BYTES);
endfunction

function automatic vaddr_t expected_commit_target(flush_kind_t kind, vaddr_t epc,
    cause_t cause, vaddr_t mtvec, vaddr_t stvec, vaddr_t mepc, vaddr_t sepc,
    medeleg_t medeleg);
  vaddr_t target;
  case (kind)
    SILENT:    target = epc + 32'd4;
    REFETCH:   target = epc;
    MRET:      target = mepc;
    SRET:      target = sepc;
    // delegated causes go to the supervisor vector
    EXCEPT:    target = medeleg[cause] ? stvec : mtvec;
    // mode bit cleared, one word per cause
    INTERRUPT: target = {mtvec[`FE_XLEN-1:1], 1'b0} + vaddr_t'(cause) * 32'd4;
    default:   target = epc;
  endcase
  return align_down(target);
endfunction

// ====================
// stimulus and block capture
// ====================

task automatic drop_blocks();
  blk_vaddr_q.delete();
  blk_pred_q.delete();
  blk_target_q.delete();
endtask

// one cycle commit flush, then forget whatever left before it
task automatic pulse_commit_flush(input flush_kind_t kind, input vaddr_t epc,
    input cause_t cause);
  @(negedge i_clk);
  i_cmt_flush = 1'b1;
  i_cmt_kind  = kind;
  i_cmt_epc   = epc;
  i_cmt_cause = cause;
  @(negedge i_clk);
  i_cmt_flush = 1'b0;
  drop_blocks();
endtask

task automatic pulse_branch(input logic mispredict, input logic taken, input vaddr_t pc,
    input vaddr_t target);
  @(negedge i_clk);
  i_br_valid      = 1'b1;
  i_br_mispredict = mispredict;
  i_br_taken      = taken;
  i_br_pc         = pc;
  i_br_target     = target;
  @(negedge i_clk);
  i_br_valid      = 1'b0;
  i_br_mispredict = 1'b0;
  drop_blocks();
endtask

// wait for the next delivered block, bounded
task automatic expect_block(input string name, input vaddr_t exp_vaddr, input logic exp_pred,
    output vaddr_t pred_target);
  int waited;
  waited = 0;
  pred_target = '0;
  while (blk_vaddr_q.size() == 0 && waited < BLOCK_WAIT_CYCLES) begin
    @(negedge i_clk);
    waited++;
  end
  if (blk_vaddr_q.size() == 0) begin
    $display("ERROR %s got no block within %0d cycles", name, BLOCK_WAIT_CYCLES);
    error_count++;
  end else begin
    check_vaddr(name, exp_vaddr, blk_vaddr_q.pop_front());
    check_bit({name, " pred"}, exp_pred, blk_pred_q.pop_front());
    pred_target = blk_target_q.pop_front();
  end
endtask

// ====================
// directed tests
// ====================

task automatic test_reset_sequential();
  int     start_errors;
  vaddr_t exp_vaddr;
  vaddr_t pred_target;
  start_errors = error_count;
  exp_vaddr = vaddr_t'(`FE_RESET_VADDR);
  repeat (8) begin
    expect_block("reset sequential", exp_vaddr, 1'b0, pred_target);
    exp_vaddr = exp_vaddr + vaddr_t'(`FE_BLOCK_BYTES);
  end
  report_test("reset_seq", start_errors);
endtask

// random epc and csrs, delegation bit forced for the cause
task automatic run_commit_kind(input string name, input flush_kind_t kind,
    input logic deleg_bit);
  vaddr_t epc;
  cause_t cause;
  vaddr_t exp_vaddr;
  vaddr_t pred_target;
  epc   = $urandom();
  // odd word so epc plus 4 lands in the next block
  epc[2] = 1'b1;
  // cause from 2 up so the interrupt offset leaves the base block
  cause = cause_t'($urandom_range(15, 2));
  @(negedge i_clk);
  i_csr_mtvec   = $urandom();
  i_csr_stvec   = $urandom();
  i_csr_mepc    = $urandom();
  i_csr_sepc    = $urandom();
  i_csr_medeleg = medeleg_t'($urandom());
  i_csr_medeleg[cause] = deleg_bit;
  exp_vaddr = expected_commit_target(kind, epc, cause, i_csr_mtvec, i_csr_stvec,
                                     i_csr_mepc, i_csr_sepc, i_csr_medeleg);
  pulse_commit_flush(kind, epc, cause);
  expect_block(name, exp_vaddr, 1'b0, pred_target);
endtask

task automatic test_commit_targets();
  int start_errors;
  start_errors = error_count;
  run_commit_kind("flush silent", SILENT, 1'b0);
  run_commit_kind("flush refetch", REFETCH, 1'b0);
  run_commit_kind("flush mret", MRET, 1'b0);
  run_commit_kind("flush sret", SRET, 1'b0);
  run_commit_kind("flush except deleg", EXCEPT, 1'b1);
  run_commit_kind("flush except machine", EXCEPT, 1'b0);
  run_commit_kind("flush interrupt", INTERRUPT, 1'b0);
  report_test("commit_targets", start_errors);
endtask

task automatic test_branch_priority();
  int     start_errors;
  vaddr_t pc;
  vaddr_t target;
  vaddr_t epc;
  vaddr_t pred_target;
  start_errors = error_count;
  pc     = 32'h0020_0000 | ($urandom() & 32'h000f_fffc);
  target = pc + 32'h0000_0200 + ($urandom() & 32'h0000_00fc);
  // taken mispredict goes to the target
  pulse_branch(1'b1, 1'b1, pc, target);
  expect_block("mispredict taken", align_down(target), 1'b0, pred_target);
  // not taken goes to the block after the branch, entry cleared
  pulse_branch(1'b1, 1'b0, pc, target);
  expect_block("mispredict not taken", align_down(pc) + 32'd8, 1'b0, pred_target);
  // commit and branch flush together
  epc = $urandom();
  @(negedge i_clk);
  i_cmt_flush     = 1'b1;
  i_cmt_kind      = REFETCH;
  i_cmt_epc       = epc;
  i_br_valid      = 1'b1;
  i_br_mispredict = 1'b1;
  i_br_taken      = 1'b0;
  i_br_pc         = pc;
  @(negedge i_clk);
  i_cmt_flush     = 1'b0;
  i_br_valid      = 1'b0;
  i_br_mispredict = 1'b0;
  drop_blocks();
  expect_block("commit over branch", align_down(epc), 1'b0, pred_target);
  report_test("branch_priority", start_errors);
endtask

task automatic test_btb_predict();
  int     start_errors;
  vaddr_t base;
  vaddr_t blk_x;
  vaddr_t tgt_x;
  vaddr_t pred_target;
  vaddr_t blocks [5];
  vaddr_t targets [5];
  string  name;
  start_errors = error_count;
  base  = 32'h0000_4000;
  blk_x = base + 32'd16;
  // unaligned on purpose
  tgt_x = 32'h0000_6004;
  pulse_branch(1'b0, 1'b1, blk_x + 32'd4, tgt_x);
  pulse_commit_flush(REFETCH, base, '0);
  expect_block("btb walk", base, 1'b0, pred_target);
  expect_block("btb walk", base + 32'd8, 1'b0, pred_target);
  expect_block("btb hit", blk_x, 1'b1, pred_target);
  check_vaddr("btb hit target", tgt_x, pred_target);
  expect_block("btb target block", align_down(tgt_x), 1'b0, pred_target);
  // not taken clears the entry
  pulse_branch(1'b0, 1'b0, blk_x + 32'd4, tgt_x);
  pulse_commit_flush(REFETCH, base, '0);
  expect_block("btb cleared walk", base, 1'b0, pred_target);
  expect_block("btb cleared walk", base + 32'd8, 1'b0, pred_target);
  expect_block("btb cleared", blk_x, 1'b0, pred_target);
  expect_block("btb cleared next", blk_x + 32'd8, 1'b0, pred_target);
  // five installs into four entries
  for (int i = 0; i < 5; i++) begin
    blocks[i]  = 32'h0001_0000 + vaddr_t'(i) * 32'h40;
    targets[i] = 32'h0003_0004 + vaddr_t'(i) * 32'h100;
    pulse_branch(1'b0, 1'b1, blocks[i], targets[i]);
  end
  // the oldest one is gone, the rest still predict
  for (int i = 0; i < 5; i++) begin
    name = $sformatf("btb evict block %0d", i);
    pulse_commit_flush(REFETCH, blocks[i], '0);
    expect_block(name, blocks[i], (i != 0), pred_target);
    if (i != 0) begin
      check_vaddr({name, " target"}, targets[i], pred_target);
    end
  end
  report_test("btb_predict", start_errors);
endtask

task automatic test_backpressure();
  int     start_errors;
  int     got;
  int     cycles;
  int     stretch;
  vaddr_t exp_vaddr;
  start_errors = error_count;
  exp_vaddr = 32'h0008_0000;
  got       = 0;
  cycles    = 0;
  stretch   = 0;
  pulse_commit_flush(REFETCH, exp_vaddr, '0);
  while (got < 24 && cycles < 200) begin
    @(negedge i_clk);
    // alternate ready low and high stretches
    if (stretch == 0) begin
      i_ibuf_ready = ~i_ibuf_ready;
      stretch      = $urandom_range(4, 1);
    end
    stretch--;
    cycles++;
    while (blk_vaddr_q.size() > 0) begin
      check_vaddr("backpressure block", exp_vaddr, blk_vaddr_q.pop_front());
      check_bit("backpressure pred", 1'b0, blk_pred_q.pop_front());
      void'(blk_target_q.pop_front());
      exp_vaddr = exp_vaddr + vaddr_t'(`FE_BLOCK_BYTES);
      got++;
    end
  end
  i_ibuf_ready = 1'b1;
  if (got < 24) begin
    $display("ERROR backpressure delivered only %0d of 24 blocks", got);
    error_count++;
  end
  report_test("backpressure", start_errors);
endtask

`endif

/* testbench/tb_frontend.sv */
// ====================
// testbench for the fetch front end, directed tests on the block stream
// ====================

`timescale 1ns/1ps

`include "frontend_defines.svh"

module tb_frontend;
  import frontend_pkg::*;

  // directed tests take about 1000 cycles, doubled
  localparam int TIMEOUT_CYCLES = 2000;
  // longest wait for a single delivered block
  localparam int BLOCK_WAIT_CYCLES = 32;

  logic        i_clk;
  logic        i_reset_n;
  logic        i_cmt_flush;
  flush_kind_t i_cmt_kind;
  vaddr_t      i_cmt_epc;
  cause_t      i_cmt_cause;
  vaddr_t      i_csr_mtvec;
  vaddr_t      i_csr_stvec;
  vaddr_t      i_csr_mepc;
  vaddr_t      i_csr_sepc;
  medeleg_t    i_csr_medeleg;
  logic        i_br_valid;
  logic        i_br_mispredict;
  logic        i_br_taken;
  vaddr_t      i_br_pc;
  vaddr_t      i_br_target;
  logic        i_ibuf_ready;
  logic        o_fetch_valid;
  vaddr_t      o_fetch_vaddr;
  logic        o_fetch_pred_taken;
  vaddr_t      o_fetch_pred_target;

  // delivered blocks, oldest first
  vaddr_t blk_vaddr_q  [$];
  logic   blk_pred_q   [$];
  vaddr_t blk_target_q [$];

  int error_count = 0;
  int check_count = 0;
  int cycle_count = 0;

  frontend_top i_dut (
    .i_clk               (i_clk),
    .i_reset_n           (i_reset_n),
    .i_cmt_flush         (i_cmt_flush),
    .i_cmt_kind          (i_cmt_kind),
    .i_cmt_epc           (i_cmt_epc),
    .i_cmt_cause         (i_cmt_cause),
    .i_csr_mtvec         (i_csr_mtvec),
    .i_csr_stvec         (i_csr_stvec),
    .i_csr_mepc          (i_csr_mepc),
    .i_csr_sepc          (i_csr_sepc),
    .i_csr_medeleg       (i_csr_medeleg),
    .i_br_valid          (i_br_valid),
    .i_br_mispredict     (i_br_mispredict),
    .i_br_taken          (i_br_taken),
    .i_br_pc             (i_br_pc),
    .i_br_target         (i_br_target),
    .i_ibuf_ready        (i_ibuf_ready),
    .o_fetch_valid       (o_fetch_valid),
    .o_fetch_vaddr       (o_fetch_vaddr),
    .o_fetch_pred_taken  (o_fetch_pred_taken),
    .o_fetch_pred_target (o_fetch_pred_target)
  );

  // 10 ns clock
  always #5 i_clk = ~i_clk;

  // ====================
  // monitor and timeout
  // ====================

  // a block counts when valid and ready meet at an edge
  always @(posedge i_clk) begin
    if (i_reset_n && o_fetch_valid && i_ibuf_ready) begin
      blk_vaddr_q.push_back(o_fetch_vaddr);
      blk_pred_q.push_back(o_fetch_pred_taken);
      blk_target_q.push_back(o_fetch_pred_target);
    end
  end

  always @(posedge i_clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("ERROR run stopped by timeout after %0d cycles", cycle_count);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  `include "tb_frontend_tasks.svh"

  // ====================
  // test sequence
  // ====================

  initial begin
    void'($urandom(72));
    i_clk           = 1'b0;
    i_reset_n       = 1'b0;
    i_cmt_flush     = 1'b0;
    i_cmt_kind      = SILENT;
    i_cmt_epc       = '0;
    i_cmt_cause     = '0;
    i_csr_mtvec     = '0;
    i_csr_stvec     = '0;
    i_csr_mepc      = '0;
    i_csr_sepc      = '0;
    i_csr_medeleg   = '0;
    i_br_valid      = 1'b0;
    i_br_mispredict = 1'b0;
    i_br_taken      = 1'b0;
    i_br_pc         = '0;
    i_br_target     = '0;
    i_ibuf_ready    = 1'b1;

    // reset for 4 cycles, released on a falling edge
    repeat (4) @(negedge i_clk);
    i_reset_n = 1'b1;

    test_reset_sequential();
    test_commit_targets();
    test_branch_priority();
    test_btb_predict();
    test_backpressure();

    $display("checks %0d errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
